//--- dv/rename_stim.txt
// Digits: dispatch, op, dest, src1, src2, retire, flush (one line per cycle)
// op: 0 alu, 1 load, 2 store, 3 branch, 4 nop
1012300
1123400
1031100
1211200
0000000
1300100
1400000
1014300
1155600
1066700
1177000
1001200
1022300
1212300
1033310
0000010
0000010
1044100
0000010
1055211
0000000
1041200
1113000
1244100
1060410
1300010
0000010
1022100
0000010
1400011
1032100
1400000
0000010
0000000
0000000

//--- dv/rename_model.svh
`ifndef rename_model_svh
`define rename_model_svh

// Reference model of the rename stage kept inside tb_rename
// Uses arch_regs and phys_regs of the including module

int exp_spec_map  [arch_regs]; // Speculative map
int exp_arch_map  [arch_regs]; // Committed map
int exp_spec_fl   [$];         // Speculative free tags with the head first
int exp_commit_fl [$];         // Checkpoint copy of the free list

// Expected result of the dispatch the DUT samples at the next edge
bit exp_valid;
bit exp_reject;
bit exp_has_dest;
int exp_src1;
int exp_src2;
int exp_dest;
int exp_old_dest;

// Only ALU ops and loads own a destination
function automatic bit writes_register(input rename_op_e op);
	return (op == op_alu) || (op == op_load);
endfunction

task automatic reset_model();
	exp_spec_fl.delete();
	exp_commit_fl.delete();
	for (int i = 0; i < arch_regs; i++) begin
		exp_spec_map[i] = i; // Identity mapping
		exp_arch_map[i] = i;
	end
	for (int t = arch_regs; t < phys_regs; t++) begin
		exp_spec_fl.push_back(t); // Ascending from arch_regs
		exp_commit_fl.push_back(t);
	end
	exp_valid  = 1'b0;
	exp_reject = 1'b0;
endtask

// Dispatch is judged on the old state and the retire then updates both lists
task automatic step_model(input bit disp, input rename_op_e op, input int dest,
		input int src1, input int src2, input bit ret, input bit ret_dest,
		input int ret_arch, input int ret_phys, input bit flush);
	bit needs_tag;
	int freed;
	needs_tag    = writes_register(op);
	exp_valid    = 1'b0;
	exp_reject   = 1'b0;
	exp_has_dest = 1'b0;
	if (disp && !(ret && flush)) begin // Flush swallows the dispatch
		if (needs_tag && exp_spec_fl.size() == 0) begin
			exp_reject = 1'b1; // Same-cycle freed tag does not count
		end else begin
			exp_valid    = 1'b1;
			exp_src1     = exp_spec_map[src1];
			exp_src2     = exp_spec_map[src2];
			exp_has_dest = needs_tag;
			exp_dest     = 0;
			exp_old_dest = 0;
			if (needs_tag) begin
				exp_dest           = exp_spec_fl.pop_front();
				exp_old_dest       = exp_spec_map[dest];
				exp_spec_map[dest] = exp_dest;
			end
		end
	end
	if (ret && ret_dest) begin
		freed                  = exp_arch_map[ret_arch]; // Previous committed tag
		exp_arch_map[ret_arch] = ret_phys;
		void'(exp_commit_fl.pop_front()); // Retiring tag leaves the checkpoint
		exp_commit_fl.push_back(freed);
		exp_spec_fl.push_back(freed);
	end
	// Restore includes this retirement
	if (ret && flush) begin
		exp_spec_fl  = exp_commit_fl;
		exp_spec_map = exp_arch_map;
	end
endtask

`endif

//--- dv/tb_rename.sv
`timescale 1ns/1ns

module tb_rename
	import rename_pkg::*;
();

	localparam int arch_regs = default_arch_regs;
	localparam int phys_regs = default_phys_regs;
	localparam int arch_w    = $clog2(arch_regs);
	localparam int tag_w     = $clog2(phys_regs);
	localparam int cnt_w     = $clog2(phys_regs - arch_regs + 1);
	localparam int max_lines = 256;

	logic              clock;
	logic              reset;
	logic              dispatch;
	rename_op_e        op;
	logic [arch_w-1:0] dest_arch;
	logic [arch_w-1:0] src1_arch;
	logic [arch_w-1:0] src2_arch;
	logic              retire;
	logic              retire_has_dest;
	logic [arch_w-1:0] retire_arch;
	logic [tag_w-1:0]  retire_phys;
	logic              retire_flush;
	logic              ren_valid;
	logic              ren_reject;
	logic [tag_w-1:0]  ren_src1;
	logic [tag_w-1:0]  ren_src2;
	logic [tag_w-1:0]  ren_dest;
	logic              ren_has_dest;
	logic [tag_w-1:0]  ren_old_dest;
	logic [cnt_w-1:0]  free_count;
	logic              empty;

	logic [27:0] stim_mem [max_lines]; // One hex digit per field
	int n_lines;
	int cycles;  // Counted after reset
	int checks;
	int errors;

	// Reorder buffer stand-in with the oldest entry first
	bit rob_has_dest [$];
	int rob_arch     [$];
	int rob_phys     [$];

	// Fields of the line being driven this cycle
	bit         cur_disp;
	rename_op_e cur_op;
	int         cur_dest, cur_src1, cur_src2;
	bit         cur_ret, cur_ret_dest, cur_flush;
	int         cur_ret_arch, cur_ret_phys;

	`include "rename_model.svh"

	rename_unit #(.arch_regs(arch_regs), .phys_regs(phys_regs)) i_dut (.*);

	always #4 clock = ~clock; // 8 ns period

	// Top digit F never occurs in a stimulus line
	function automatic logic [27:0] unused_word(input int addr);
		return {4'hf, 24'(addr)};
	endfunction

	// Decodes one line and picks the retiring instruction before driving the DUT
	task automatic drive_line(input logic [27:0] word);
		cur_disp     = word[24];
		cur_op       = rename_op_e'(word[22:20]);
		cur_dest     = word[19:16];
		cur_src1     = word[15:12];
		cur_src2     = word[11:8];
		cur_ret      = 1'b0;
		cur_ret_dest = 1'b0;
		cur_ret_arch = 0;
		cur_ret_phys = 0;
		cur_flush    = 1'b0;
		if (word[4] && rob_arch.size() > 0) begin // Nothing to retire otherwise
			cur_ret      = 1'b1;
			cur_ret_dest = rob_has_dest.pop_front();
			cur_ret_arch = rob_arch.pop_front();
			cur_ret_phys = rob_phys.pop_front();
			cur_flush    = word[0];
			if (cur_flush) begin // Younger instructions are squashed
				rob_has_dest.delete();
				rob_arch.delete();
				rob_phys.delete();
			end
		end
		dispatch        <= cur_disp;
		op              <= cur_op;
		dest_arch       <= arch_w'(cur_dest);
		src1_arch       <= arch_w'(cur_src1);
		src2_arch       <= arch_w'(cur_src2);
		retire          <= cur_ret;
		retire_has_dest <= cur_ret_dest;
		retire_arch     <= arch_w'(cur_ret_arch);
		retire_phys     <= tag_w'(cur_ret_phys);
		retire_flush    <= cur_flush;
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERR %0t ns %s expected %0d got %0d", $time, name, exp, got);
		end
	endtask

	// Outputs after an edge against the model state after the same edge
	task automatic check_outputs();
		compare_value("ren_valid", ren_valid, exp_valid);
		compare_value("ren_reject", ren_reject, exp_reject);
		if (exp_valid) begin
			compare_value("ren_src1", ren_src1, exp_src1);
			compare_value("ren_src2", ren_src2, exp_src2);
			compare_value("ren_has_dest", ren_has_dest, exp_has_dest);
			compare_value("ren_dest", ren_dest, exp_dest);
			compare_value("ren_old_dest", ren_old_dest, exp_old_dest);
		end
		compare_value("free_count", free_count, exp_spec_fl.size());
		compare_value("empty", empty, exp_spec_fl.size() == 0);
	endtask

	// Run length guard
	always @(posedge clock) begin
		if (!reset) begin
			cycles <= cycles + 1;
			if (cycles >= n_lines + 20) begin
				$display("Timeout, stimulus did not finish within %0d cycles", n_lines + 20);
				$display("ERRORS FOUND");
				$finish;
			end
		end
	end

	initial begin
		clock           = 1'b0;
		reset           = 1'b1;
		dispatch        = 1'b0;
		op              = op_nop;
		dest_arch       = '0;
		src1_arch       = '0;
		src2_arch       = '0;
		retire          = 1'b0;
		retire_has_dest = 1'b0;
		retire_arch     = '0;
		retire_phys     = '0;
		retire_flush    = 1'b0;
		cycles          = 0;
		checks          = 0;
		errors          = 0;
		for (int i = 0; i < max_lines; i++) begin
			stim_mem[i] = unused_word(i);
		end
		$readmemh("dv/rename_stim.txt", stim_mem);
		n_lines = 0;
		while (n_lines < max_lines && stim_mem[n_lines] != unused_word(n_lines)) begin
			n_lines++;
		end
		if (n_lines == 0) begin
			errors++;
			$display("Stimulus file dv/rename_stim.txt gave no lines");
		end
		reset_model();
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		// One extra idle line lets the last dispatch be checked
		for (int i = 0; i <= n_lines; i++) begin
			@(posedge clock);
			if (i < n_lines) begin
				drive_line(stim_mem[i]);
			end else begin
				drive_line('0);
			end
			@(negedge clock);
			check_outputs();
			step_model(cur_disp, cur_op, cur_dest, cur_src1, cur_src2,
				cur_ret, cur_ret_dest, cur_ret_arch, cur_ret_phys, cur_flush);
			if (exp_valid) begin // Renamed instruction enters the ROB
				rob_has_dest.push_back(exp_has_dest);
				rob_arch.push_back(cur_dest);
				rob_phys.push_back(exp_dest);
			end
		end
		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+dv
rtl/rename_pkg.sv
rtl/rename_dispatch.sv
rtl/free_list.sv
rtl/map_table.sv
rtl/arch_map.sv
rtl/rename_output.sv
rtl/rename_unit.sv
dv/tb_rename.sv

//--- rtl/arch_map.sv
`timescale 1ns/1ns

module arch_map
	import rename_pkg::*;
#(
	parameter  int arch_regs = default_arch_regs,
	parameter  int phys_regs = default_phys_regs,
	localparam int arch_w    = $clog2(arch_regs),
	localparam int tag_w     = $clog2(phys_regs)
) (
	input  logic                            clock,
	input  logic                            reset,
	input  logic                            retire,          // In-order strobe from the ROB
	input  logic                            retire_has_dest,
	input  logic [arch_w-1:0]               retire_arch,
	input  logic [tag_w-1:0]                retire_phys,
	output logic [tag_w-1:0]                old_committed,   // Tag to free
	output logic                            release_en,
	output logic [arch_regs-1:0][tag_w-1:0] committed_map
);

	logic [arch_regs-1:0][tag_w-1:0] arch_tbl;      // Committed mapping
	logic [arch_regs-1:0][tag_w-1:0] arch_tbl_next;

	// Only retirements that write a register free anything
	assign release_en    = retire && retire_has_dest;
	assign old_committed = arch_tbl[retire_arch];

	always_comb begin
		arch_tbl_next = arch_tbl;
		if (release_en) begin
			arch_tbl_next[retire_arch] = retire_phys;
		end
	end

	// Restore path needs the map with this retirement already applied
	assign committed_map = arch_tbl_next;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < arch_regs; i++) begin
				arch_tbl[i] <= tag_w'(i);
			end
		end else begin
			arch_tbl <= arch_tbl_next;
		end
	end

endmodule

//--- rtl/free_list.sv
`timescale 1ns/1ns

module free_list
	import rename_pkg::*;
#(
	parameter  int arch_regs = default_arch_regs,
	parameter  int phys_regs = default_phys_regs,
	localparam int fl_size   = phys_regs - arch_regs,
	localparam int tag_w     = $clog2(phys_regs),
	localparam int cnt_w     = $clog2(fl_size + 1)
) (
	input  logic             clock,
	input  logic             reset,
	input  logic             alloc,       // Hand out the head tag
	input  logic             release_en,  // Old committed tag comes back
	input  logic [tag_w-1:0] release_tag,
	input  logic             commit_pop,  // Retiring dest takes its tag out of the checkpoint
	input  logic             flush,       // Restore from checkpoint
	output logic [tag_w-1:0] head_tag,
	output logic [cnt_w-1:0] free_count,
	output logic             empty
);

	// Speculative queue, head at index 0
	logic [fl_size-1:0][tag_w-1:0] spec_q;
	logic [fl_size-1:0][tag_w-1:0] spec_q_next;
	logic [cnt_w-1:0]              spec_cnt;
	logic [cnt_w-1:0]              spec_cnt_next;

	// Committed queue acts as the checkpoint
	logic [fl_size-1:0][tag_w-1:0] commit_q;
	logic [fl_size-1:0][tag_w-1:0] commit_q_next;
	logic [cnt_w-1:0]              commit_cnt;
	logic [cnt_w-1:0]              commit_cnt_next;

	assign head_tag   = spec_q[0];
	assign free_count = spec_cnt;
	assign empty      = (spec_cnt == '0);

	// Checkpoint update at retirement
	always_comb begin
		commit_q_next   = commit_q;
		commit_cnt_next = commit_cnt;
		if (commit_pop && commit_cnt != '0) begin
			for (int i = 0; i < fl_size - 1; i++) begin
				commit_q_next[i] = commit_q[i + 1]; // Shift toward head
			end
			commit_cnt_next = commit_cnt - 1'b1;
		end
		// Append lands after the shift so both happen in one step
		if (release_en && commit_cnt_next < cnt_w'(fl_size)) begin
			commit_q_next[commit_cnt_next] = release_tag;
			commit_cnt_next                = commit_cnt_next + 1'b1;
		end
	end

	// Speculative update
	always_comb begin
		spec_q_next   = spec_q;
		spec_cnt_next = spec_cnt;
		if (alloc && spec_cnt != '0) begin
			for (int i = 0; i < fl_size - 1; i++) begin
				spec_q_next[i] = spec_q[i + 1];
			end
			spec_cnt_next = spec_cnt - 1'b1;
		end
		if (release_en && spec_cnt_next < cnt_w'(fl_size)) begin
			spec_q_next[spec_cnt_next] = release_tag; // Freed tag goes to the tail
			spec_cnt_next              = spec_cnt_next + 1'b1;
		end
		// Mispredict takes the checkpoint including this cycle's retirement
		if (flush) begin
			spec_q_next   = commit_q_next;
			spec_cnt_next = commit_cnt_next;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			// Tags below arch_regs hold the identity mapping
			for (int i = 0; i < fl_size; i++) begin
				spec_q[i]   <= tag_w'(arch_regs + i);
				commit_q[i] <= tag_w'(arch_regs + i);
			end
			spec_cnt   <= cnt_w'(fl_size);
			commit_cnt <= cnt_w'(fl_size);
		end else begin
			spec_q     <= spec_q_next;
			spec_cnt   <= spec_cnt_next;
			commit_q   <= commit_q_next;
			commit_cnt <= commit_cnt_next;
		end
	end

endmodule

//--- rtl/map_table.sv
`timescale 1ns/1ns

module map_table
	import rename_pkg::*;
#(
	parameter  int arch_regs = default_arch_regs,
	parameter  int phys_regs = default_phys_regs,
	localparam int arch_w    = $clog2(arch_regs),
	localparam int tag_w     = $clog2(phys_regs)
) (
	input  logic                          clock,
	input  logic                          reset,
	input  logic [arch_w-1:0]             src1_arch,
	input  logic [arch_w-1:0]             src2_arch,
	input  logic                          write,         // New mapping from alloc
	input  logic [arch_w-1:0]             dest_arch,
	input  logic [tag_w-1:0]              dest_tag,
	input  logic                          flush,
	input  logic [arch_regs-1:0][tag_w-1:0] committed_map, // Next-state committed view
	output logic [tag_w-1:0]              src1_tag,
	output logic [tag_w-1:0]              src2_tag,
	output logic [tag_w-1:0]              old_tag
);

	// Speculative map, one tag per architectural register
	logic [arch_regs-1:0][tag_w-1:0] spec_map;

	// Reads see the table before this cycle's write
	assign src1_tag = spec_map[src1_arch];
	assign src2_tag = spec_map[src2_arch];
	assign old_tag  = spec_map[dest_arch]; // Mapping being replaced

	// A source equal to the destination still reads the older tag
	// which is what the instruction itself consumes

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < arch_regs; i++) begin
				spec_map[i] <= tag_w'(i); // Identity after reset
			end
		end else if (flush) begin
			spec_map <= committed_map; // Whole table in one edge
		end else if (write) begin
			spec_map[dest_arch] <= dest_tag;
		end
	end

endmodule

//--- rtl/rename_dispatch.sv
`timescale 1ns/1ns

module rename_dispatch
	import rename_pkg::*;
(
	input  logic       dispatch,     // One-cycle strobe from decode
	input  rename_op_e op,
	input  logic       empty,        // Registered free list state
	input  logic       retire_flush, // Mispredict retiring this cycle
	output logic       accept,
	output logic       reject,
	output logic       alloc,
	output logic       has_dest
);

	logic writes_dest; // Opcode needs a physical tag
	logic no_tag;      // Needs a tag but none is free

	// Opcode classification
	always_comb begin
		case (op)
			op_alu,
			op_load:   writes_dest = 1'b1;
			op_store,
			op_branch,
			op_nop:    writes_dest = 1'b0;
			default:   writes_dest = 1'b0;
		endcase
	end

	// Empty is the registered view so a tag freed this cycle is not usable yet
	assign no_tag = writes_dest && empty;

	// Flush wins over everything and the dispatch simply vanishes
	assign accept = dispatch && !retire_flush && !no_tag;
	assign reject = dispatch && !retire_flush && no_tag;

	// Pop the free list and write the map only when something is renamed
	assign alloc    = accept && writes_dest;
	assign has_dest = writes_dest;

endmodule

//--- rtl/rename_output.sv
`timescale 1ns/1ns

module rename_output
	import rename_pkg::*;
#(
	parameter  int phys_regs = default_phys_regs,
	localparam int tag_w     = $clog2(phys_regs)
) (
	input  logic             clock,
	input  logic             reset,
	input  logic             accept,
	input  logic             reject,
	input  logic             has_dest,
	input  logic [tag_w-1:0] src1_tag,
	input  logic [tag_w-1:0] src2_tag,
	input  logic [tag_w-1:0] head_tag, // Tag popped this cycle
	input  logic [tag_w-1:0] old_tag,
	output logic             ren_valid,
	output logic             ren_reject,
	output logic [tag_w-1:0] ren_src1,
	output logic [tag_w-1:0] ren_src2,
	output logic [tag_w-1:0] ren_dest,
	output logic             ren_has_dest,
	output logic [tag_w-1:0] ren_old_dest
);

	// Strobes last exactly one cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			ren_valid  <= 1'b0;
			ren_reject <= 1'b0;
		end else begin
			ren_valid  <= accept;
			ren_reject <= reject;
		end
	end

	// Payload only meaningful with ren_valid
	always_ff @(posedge clock) begin
		if (accept) begin
			ren_src1     <= src1_tag;
			ren_src2     <= src2_tag;
			ren_has_dest <= has_dest;
			ren_dest     <= has_dest ? head_tag : '0; // Zero when nothing is written
			ren_old_dest <= has_dest ? old_tag : '0;
		end
	end

endmodule

//--- rtl/rename_pkg.sv
package rename_pkg;

	// Opcode classes seen by the rename stage
	typedef enum logic [2:0] {
		op_alu    = 3'd0, // Writes a destination
		op_load   = 3'd1, // Writes a destination
		op_store  = 3'd2,
		op_branch = 3'd3,
		op_nop    = 3'd4
	} rename_op_e;

	// Default machine size
	localparam int default_arch_regs = 8;  // Architectural registers
	localparam int default_phys_regs = 16; // Physical registers

	// Free list depth follows as phys minus arch

endpackage

//--- rtl/rename_unit.sv
`timescale 1ns/1ns

module rename_unit
	import rename_pkg::*;
#(
	parameter  int arch_regs = default_arch_regs,
	parameter  int phys_regs = default_phys_regs,
	localparam int arch_w    = $clog2(arch_regs),
	localparam int tag_w     = $clog2(phys_regs),
	localparam int cnt_w     = $clog2(phys_regs - arch_regs + 1)
) (
	input  logic              clock,
	input  logic              reset,
	// Dispatch
	input  logic              dispatch,
	input  rename_op_e        op,
	input  logic [arch_w-1:0] dest_arch,
	input  logic [arch_w-1:0] src1_arch,
	input  logic [arch_w-1:0] src2_arch,
	// Retire from the ROB
	input  logic              retire,
	input  logic              retire_has_dest,
	input  logic [arch_w-1:0] retire_arch,
	input  logic [tag_w-1:0]  retire_phys,
	input  logic              retire_flush,
	// Result
	output logic              ren_valid,
	output logic              ren_reject,
	output logic [tag_w-1:0]  ren_src1,
	output logic [tag_w-1:0]  ren_src2,
	output logic [tag_w-1:0]  ren_dest,
	output logic              ren_has_dest,
	output logic [tag_w-1:0]  ren_old_dest,
	// Status
	output logic [cnt_w-1:0]  free_count,
	output logic              empty
);

	logic                            accept, reject, alloc, has_dest;
	logic [tag_w-1:0]                head_tag, src1_tag, src2_tag, old_tag;
	logic [tag_w-1:0]                old_committed;
	logic                            release_en;    // Also pops the checkpoint
	logic [arch_regs-1:0][tag_w-1:0] committed_map;

	rename_dispatch u_dispatch (
		.dispatch, .op, .empty, .retire_flush,
		.accept, .reject, .alloc, .has_dest
	);

	free_list #(.arch_regs(arch_regs), .phys_regs(phys_regs)) u_free_list (
		.clock, .reset, .alloc, .release_en,
		.release_tag(old_committed), .commit_pop(release_en), .flush(retire_flush),
		.head_tag, .free_count, .empty
	);

	map_table #(.arch_regs(arch_regs), .phys_regs(phys_regs)) u_map_table (
		.clock, .reset, .src1_arch, .src2_arch,
		.write(alloc), .dest_arch, .dest_tag(head_tag), .flush(retire_flush),
		.committed_map, .src1_tag, .src2_tag, .old_tag
	);

	arch_map #(.arch_regs(arch_regs), .phys_regs(phys_regs)) u_arch_map (
		.clock, .reset, .retire, .retire_has_dest, .retire_arch, .retire_phys,
		.old_committed, .release_en, .committed_map
	);

	rename_output #(.phys_regs(phys_regs)) u_output (
		.clock, .reset, .accept, .reject, .has_dest,
		.src1_tag, .src2_tag, .head_tag, .old_tag,
		.ren_valid, .ren_reject, .ren_src1, .ren_src2,
		.ren_dest, .ren_has_dest, .ren_old_dest
	);

endmodule

//--- run.sh
#!/usr/bin/env bash
# Compile and run the rename testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_rename -f project.f -o sim_rename \
	|| { echo "Verilator build failed"; exit 1; }

./obj_dir/sim_rename 2>&1 | tee sim.log \
	|| { echo "Simulation exited with an error"; exit 1; }

# Verdict comes from the log
grep -q "ERRORS FOUND" sim.log && { echo "Result: FAIL"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "Result: no verdict in log"; exit 1; }
echo "Result: PASS"
exit 0
